// File: logic/adc_acq_pkg.sv
`default_nettype none

package adc_acq_pkg;

    // dummy adc sample and data word packing
    localparam int SAMPLE_W = 12;
    localparam int SAMPLES_PER_WORD = 4;

    // output word is a kind code on top of a payload
    localparam int WORD_W = 64;
    localparam int KIND_W = 4;
    localparam int PAYLOAD_W = WORD_W - KIND_W;

    typedef enum logic [KIND_W-1:0] {
        KIND_FILL_HDR = 4'd1,
        KIND_WFM_HDR  = 4'd2,
        KIND_DATA     = 4'd3,
        KIND_CHECKSUM = 4'd4
    } word_kind_t;

    typedef struct packed {
        word_kind_t             kind;
        logic [PAYLOAD_W-1:0]   payload;
    } acq_word_t;

    // bit 0 from enable 0, bit 1 from enable 1, zero is readout mode
    typedef logic [1:0] fill_type_t;

    // data words per waveform, indexed by fill type
    localparam int BURST_CNT_W = 3;
    localparam logic [3:0][BURST_CNT_W-1:0] BURSTS_BY_TYPE = {3'd5, 3'd3, 3'd2, 3'd0};

    localparam int WAVEFORMS_PER_FILL = 3;
    localparam int WFM_CNT_W = $clog2(WAVEFORMS_PER_FILL);

    // idle cycles between waveforms
    localparam int GAP_CYCLES = 4;
    localparam int GAP_CNT_W = $clog2(GAP_CYCLES + 1);

    localparam int FILL_CNT_W = 16;

    // synchronizer depths
    localparam int SYNC_STAGES = 4;
    localparam int DONE_SYNC_STAGES = 2;

endpackage

`default_nettype wire

// File: logic/adc_acq_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface adc_acq_ctrl_if
    import adc_acq_pkg::*;
();

    // word request, one cycle, kind valid alongside
    logic                   emit;
    word_kind_t             kind;
    // context for the header words
    logic [WFM_CNT_W-1:0]   wfm_index;
    fill_type_t             fill_type;
    // restart the dummy sample counter
    logic                   dummy_reset;
    // clear the running checksum, lands with the fill header emit
    logic                   checksum_clear;
    // word handed over and ack released
    logic                   sent;

    modport sequencer (
        output emit,
        output kind,
        output wfm_index,
        output fill_type,
        output dummy_reset,
        output checksum_clear,
        input  sent
    );

    modport builder (
        input  emit,
        input  kind,
        input  wfm_index,
        input  fill_type,
        input  dummy_reset,
        input  checksum_clear,
        output sent
    );

endinterface

`default_nettype wire

// File: logic/adc_acq_sync_decode.sv
`timescale 1ns/100ps
`default_nettype none

module adc_acq_sync_decode
    import adc_acq_pkg::*;
(
    input  logic        clk,
    input  logic        adc_acq_full_reset,
    input  logic        acq_enable0,
    input  logic        acq_enable1,
    input  logic        acq_trig,
    input  logic        ddr3_wr_done,
    output logic        acq_mode_enabled,
    output fill_type_t  fill_type,
    output logic        trig_sync,
    output logic        wr_done_sync
);

    // one row per stage, bits are {trig, enable1, enable0}
    logic [SYNC_STAGES-1:0][2:0]    in_sync;
    logic [DONE_SYNC_STAGES-1:0]    done_sync;
    logic [2:0]                     in_last;

    // last stage of the trigger and enable chains
    assign in_last = in_sync[SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            in_sync <= '0;
            done_sync <= '0;
        end else begin
            // shift toward the top stage
            in_sync <= {in_sync[SYNC_STAGES-2:0], {acq_trig, acq_enable1, acq_enable0}};
            done_sync <= {done_sync[DONE_SYNC_STAGES-2:0], ddr3_wr_done};
        end
    end

    assign trig_sync = in_last[2];
    assign wr_done_sync = done_sync[DONE_SYNC_STAGES-1];

    // fill type and mode registered from the synchronized enables
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            fill_type <= '0;
            acq_mode_enabled <= 1'b0;
        end else begin
            fill_type <= fill_type_t'(in_last[1:0]);
            // readout mode only when both enables are low
            acq_mode_enabled <= in_last[1] | in_last[0];
        end
    end

endmodule

`default_nettype wire

// File: logic/adc_acq_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module adc_acq_sequencer
    import adc_acq_pkg::*;
(
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  logic                    acq_mode_enabled,
    input  fill_type_t              fill_type,
    input  logic                    trig_sync,
    input  logic                    wr_done_sync,
    input  logic                    dummy_dat_reset_mode,
    adc_acq_ctrl_if.sequencer       ctrl,
    output logic                    acq_done,
    output logic                    sm_idle,
    output logic [FILL_CNT_W-1:0]   fill_count
);

    // one-hot bit positions
    typedef enum int unsigned {
        ST_IDLE,
        ST_FILL_HDR,
        ST_WFM_HDR,
        ST_RUN,
        ST_WFM_TEST,
        ST_GAP,
        ST_CHECKSUM,
        ST_WR_WAIT,
        ST_DONE,
        ST_NUM
    } state_idx_t;

    logic [ST_NUM-1:0]      state;
    logic [ST_NUM-1:0]      state_next;
    fill_type_t             fill_type_r;
    logic [BURST_CNT_W-1:0] burst_cnt;
    logic [WFM_CNT_W-1:0]   wfm_idx;
    logic [GAP_CNT_W-1:0]   gap_cnt;
    logic                   start_fill;
    logic                   last_wfm;
    logic                   emit_state;
    logic                   emit_state_next;
    logic                   enter_fill;
    logic                   enter_wfm;

    assign start_fill = state[ST_IDLE] & acq_mode_enabled & trig_sync;
    assign last_wfm = (wfm_idx == WFM_CNT_W'(WAVEFORMS_PER_FILL - 1));

    // states that hand a word to the builder
    assign emit_state = state[ST_FILL_HDR] | state[ST_WFM_HDR] | state[ST_RUN]
                      | state[ST_CHECKSUM];
    assign emit_state_next = state_next[ST_FILL_HDR] | state_next[ST_WFM_HDR]
                           | state_next[ST_RUN] | state_next[ST_CHECKSUM];
    assign enter_fill = state_next[ST_FILL_HDR] & ~state[ST_FILL_HDR];
    assign enter_wfm = state_next[ST_WFM_HDR] & ~state[ST_WFM_HDR];

    always_comb begin
        state_next = '0;
        case (1'b1)
            // armed and triggered
            state[ST_IDLE]:
                state_next[start_fill ? ST_FILL_HDR : ST_IDLE] = 1'b1;
            state[ST_FILL_HDR]:
                state_next[ctrl.sent ? ST_WFM_HDR : ST_FILL_HDR] = 1'b1;
            state[ST_WFM_HDR]:
                state_next[ctrl.sent ? ST_RUN : ST_WFM_HDR] = 1'b1;
            // one data word per pass, last burst leaves
            state[ST_RUN]:
                if (ctrl.sent && burst_cnt == BURST_CNT_W'(1))
                    state_next[ST_WFM_TEST] = 1'b1;
                else
                    state_next[ST_RUN] = 1'b1;
            state[ST_WFM_TEST]:
                state_next[last_wfm ? ST_CHECKSUM : ST_GAP] = 1'b1;
            state[ST_GAP]:
                state_next[gap_cnt == GAP_CNT_W'(1) ? ST_WFM_HDR : ST_GAP] = 1'b1;
            state[ST_CHECKSUM]:
                state_next[ctrl.sent ? ST_WR_WAIT : ST_CHECKSUM] = 1'b1;
            // memory writer still busy
            state[ST_WR_WAIT]:
                state_next[wr_done_sync ? ST_DONE : ST_WR_WAIT] = 1'b1;
            // hold until trigger drops, no retrigger
            state[ST_DONE]:
                state_next[trig_sync ? ST_DONE : ST_IDLE] = 1'b1;
            default:
                state_next[ST_IDLE] = 1'b1;
        endcase
    end

    // state and outputs, registered from the next state
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state <= '0;
            state[ST_IDLE] <= 1'b1;
            ctrl.emit <= 1'b0;
            ctrl.kind <= KIND_FILL_HDR;
            ctrl.dummy_reset <= 1'b0;
            ctrl.checksum_clear <= 1'b0;
            acq_done <= 1'b0;
            sm_idle <= 1'b1;
        end else begin
            state <= state_next;
            // new word on entry, or again after the last one went out
            ctrl.emit <= emit_state_next & (~emit_state | ctrl.sent);
            ctrl.dummy_reset <= enter_fill | (enter_wfm & dummy_dat_reset_mode);
            ctrl.checksum_clear <= enter_fill;
            acq_done <= state_next[ST_DONE];
            sm_idle <= state_next[ST_IDLE];
            if (state_next[ST_FILL_HDR])
                ctrl.kind <= KIND_FILL_HDR;
            else if (state_next[ST_WFM_HDR])
                ctrl.kind <= KIND_WFM_HDR;
            else if (state_next[ST_RUN])
                ctrl.kind <= KIND_DATA;
            else if (state_next[ST_CHECKSUM])
                ctrl.kind <= KIND_CHECKSUM;
        end
    end

    // burst, waveform, gap and fill counters
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            fill_type_r <= '0;
            burst_cnt <= '0;
            wfm_idx <= '0;
            gap_cnt <= '0;
            fill_count <= '0;
        end else begin
            if (start_fill) begin
                fill_type_r <= fill_type;
                burst_cnt <= BURSTS_BY_TYPE[fill_type];
                wfm_idx <= '0;
            end
            if (state[ST_RUN] && ctrl.sent)
                burst_cnt <= burst_cnt - BURST_CNT_W'(1);
            // reload bursts and arm the gap for the next waveform
            if (state[ST_WFM_TEST]) begin
                burst_cnt <= BURSTS_BY_TYPE[fill_type_r];
                if (!last_wfm) begin
                    wfm_idx <= wfm_idx + WFM_CNT_W'(1);
                    gap_cnt <= GAP_CNT_W'(GAP_CYCLES);
                end
            end
            if (state[ST_GAP])
                gap_cnt <= gap_cnt - GAP_CNT_W'(1);
            if (state[ST_CHECKSUM] && ctrl.sent)
                fill_count <= fill_count + FILL_CNT_W'(1);
        end
    end

    assign ctrl.wfm_index = wfm_idx;
    assign ctrl.fill_type = fill_type_r;

endmodule

`default_nettype wire

// File: logic/adc_acq_word_builder.sv
`timescale 1ns/100ps
`default_nettype none

module adc_acq_word_builder
    import adc_acq_pkg::*;
(
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  logic [FILL_CNT_W-1:0]   fill_count,
    adc_acq_ctrl_if.builder         ctrl,
    input  logic                    out_ack,
    output logic                    out_req,
    output acq_word_t               out_word
);

    logic [SAMPLE_W-1:0]    sample_cnt;
    logic [PAYLOAD_W-1:0]   checksum;
    logic [PAYLOAD_W-1:0]   data_payload;
    acq_word_t              next_word;
    logic                   ack_seen;
    logic                   take_data;

    assign take_data = ctrl.emit & (ctrl.kind == KIND_DATA);

    // four consecutive samples, earliest in the low bits
    always_comb begin
        data_payload = '0;
        for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
            data_payload[i*SAMPLE_W +: SAMPLE_W] = sample_cnt + SAMPLE_W'(i);
        end
    end

    // word mux on the requested kind
    always_comb begin
        next_word.kind = ctrl.kind;
        case (ctrl.kind)
            KIND_FILL_HDR: next_word.payload = PAYLOAD_W'({fill_count, ctrl.fill_type});
            KIND_WFM_HDR:  next_word.payload = PAYLOAD_W'(ctrl.wfm_index);
            KIND_DATA:     next_word.payload = data_payload;
            KIND_CHECKSUM: next_word.payload = checksum;
            default:       next_word.payload = '0;
        endcase
    end

    // dummy counter and running checksum
    always_ff @(posedge clk) begin
        if (ctrl.dummy_reset)
            sample_cnt <= '0;
        else if (take_data)
            sample_cnt <= sample_cnt + SAMPLE_W'(SAMPLES_PER_WORD);
        if (ctrl.checksum_clear)
            checksum <= '0;
        else if (take_data)
            checksum <= checksum ^ data_payload;
    end

    // word held while the request is up
    always_ff @(posedge clk) begin
        if (ctrl.emit)
            out_word <= next_word;
    end

    // four-phase handshake: req up, ack up, req down, ack down
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            out_req <= 1'b0;
            ack_seen <= 1'b0;
            ctrl.sent <= 1'b0;
        end else begin
            ctrl.sent <= 1'b0;
            if (ctrl.emit) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req <= 1'b0;
                ack_seen <= 1'b1;
            end else if (ack_seen && !out_ack) begin
                // consumer released ack, word is done
                ack_seen <= 1'b0;
                ctrl.sent <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/adc_acq_top.sv
`timescale 1ns/100ps
`default_nettype none

module adc_acq_top
    import adc_acq_pkg::*;
(
    input  logic                clk,
    input  logic                adc_acq_full_reset,
    input  logic                acq_enable0,
    input  logic                acq_enable1,
    input  logic                acq_trig,
    input  logic                ddr3_wr_done,
    input  logic                dummy_dat_reset_mode,
    input  logic                out_ack,
    output logic                out_req,
    output logic [WORD_W-1:0]   out_word,
    output logic                acq_done,
    output logic                sm_idle
);

    logic                   acq_mode_enabled;
    fill_type_t             fill_type;
    logic                   trig_sync;
    logic                   wr_done_sync;
    logic [FILL_CNT_W-1:0]  fill_count;

    adc_acq_ctrl_if ctrl_if ();

    // input synchronizers and fill type decode
    adc_acq_sync_decode sync_decode_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .acq_mode_enabled   (acq_mode_enabled),
        .fill_type          (fill_type),
        .trig_sync          (trig_sync),
        .wr_done_sync       (wr_done_sync)
    );

    // fill state machine
    adc_acq_sequencer sequencer_inst (
        .clk                    (clk),
        .adc_acq_full_reset     (adc_acq_full_reset),
        .acq_mode_enabled       (acq_mode_enabled),
        .fill_type              (fill_type),
        .trig_sync              (trig_sync),
        .wr_done_sync           (wr_done_sync),
        .dummy_dat_reset_mode   (dummy_dat_reset_mode),
        .ctrl                   (ctrl_if.sequencer),
        .acq_done               (acq_done),
        .sm_idle                (sm_idle),
        .fill_count             (fill_count)
    );

    // word assembly and output handshake
    adc_acq_word_builder word_builder_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .fill_count         (fill_count),
        .ctrl               (ctrl_if.builder),
        .out_ack            (out_ack),
        .out_req            (out_req),
        .out_word           (out_word)
    );

endmodule

`default_nettype wire

// File: verification/adc_acq_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module adc_acq_asserts
    import adc_acq_pkg::*;
(
    input logic                 clk,
    input logic                 adc_acq_full_reset,
    input logic                 out_req,
    input logic                 out_ack,
    input logic [WORD_W-1:0]    out_word,
    input logic                 acq_done
);

    // failures seen so far, read by the testbench at the end
    int fail_cnt = 0;

    // word held for the whole request
    word_stable: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        out_req && $past(out_req) |-> $stable(out_word))
    else begin
        $error("out_word changed while out_req was high");
        fail_cnt++;
    end

    // req only drops once the consumer acked
    req_fall_after_ack: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        $fell(out_req) |-> $past(out_ack))
    else begin
        $error("out_req dropped without out_ack");
        fail_cnt++;
    end

    // next request waits for ack to be released
    req_rise_ack_low: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        $rose(out_req) |-> !$past(out_ack))
    else begin
        $error("out_req rose while out_ack was still high");
        fail_cnt++;
    end

    // no word goes out once the fill is done
    req_done_exclusive: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        !(out_req && acq_done))
    else begin
        $error("out_req and acq_done were high together");
        fail_cnt++;
    end

endmodule

`default_nettype wire

// File: verification/adc_acq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module adc_acq_tb
    import adc_acq_pkg::*;
();

    // six fills of at most 20 words at about 9 cycles each at the slowest ack
    // plus gaps, synchronizer settling and hold windows with wide margin
    localparam int MAX_CYCLES = 4000;
    localparam int HOLD_CYCLES = 10;
    // cycles between the closed checksum handshake and the writer done
    localparam int WR_DONE_DELAY = 4;

    logic               clk;
    logic               adc_acq_full_reset;
    logic               acq_enable0;
    logic               acq_enable1;
    logic               acq_trig;
    logic               ddr3_wr_done;
    logic               dummy_dat_reset_mode;
    logic               out_ack;
    logic               out_req;
    logic [WORD_W-1:0]  out_word;
    logic               acq_done;
    logic               sm_idle;

    // expected words with the oldest first
    logic [WORD_W-1:0]  exp_q[$];
    string              test_name = "reset";
    int                 mismatch_cnt = 0;
    int                 word_err_cnt = 0;
    int                 flow_err_cnt = 0;
    int                 checksums_seen = 0;
    int                 fills_done = 0;
    int                 cycle_cnt = 0;
    logic [7:0]         lfsr_state = 8'd63;

    adc_acq_top adc_acq_top_inst (
        .clk                    (clk),
        .adc_acq_full_reset     (adc_acq_full_reset),
        .acq_enable0            (acq_enable0),
        .acq_enable1            (acq_enable1),
        .acq_trig               (acq_trig),
        .ddr3_wr_done           (ddr3_wr_done),
        .dummy_dat_reset_mode   (dummy_dat_reset_mode),
        .out_ack                (out_ack),
        .out_req                (out_req),
        .out_word               (out_word),
        .acq_done               (acq_done),
        .sm_idle                (sm_idle)
    );

    // handshake and done checks sit inside the top level
    bind adc_acq_top adc_acq_asserts asserts_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .out_req            (out_req),
        .out_ack            (out_ack),
        .out_word           (out_word),
        .acq_done           (acq_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr with taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // two fresh bits give 0 to 3 cycles
    task automatic draw_ack_delay(output int delay);
        lfsr_state = lfsr_next(lfsr_state);
        delay = int'(lfsr_state[0]);
        lfsr_state = lfsr_next(lfsr_state);
        delay = delay + 2 * int'(lfsr_state[0]);
    endtask

    // data words per waveform for each fill type
    function automatic int bursts_for(input fill_type_t ftype);
        case (ftype)
            2'd1: return 2;
            2'd2: return 3;
            2'd3: return 5;
            default: return 0;
        endcase
    endfunction

    // reference model for the whole word sequence of one fill
    task automatic queue_fill(input fill_type_t ftype, input logic rmode);
        logic [PAYLOAD_W-1:0]   payload;
        logic [PAYLOAD_W-1:0]   xsum;
        logic [SAMPLE_W-1:0]    sample;
        xsum = '0;
        // counter restarts at every fill
        sample = '0;
        exp_q.push_back({KIND_FILL_HDR, PAYLOAD_W'({FILL_CNT_W'(fills_done), ftype})});
        for (int w = 0; w < WAVEFORMS_PER_FILL; w++) begin
            exp_q.push_back({KIND_WFM_HDR, PAYLOAD_W'(w)});
            if (rmode)
                sample = '0;
            for (int b = 0; b < bursts_for(ftype); b++) begin
                payload = '0;
                // earliest sample lowest
                for (int s = 0; s < SAMPLES_PER_WORD; s++) begin
                    payload[s*SAMPLE_W +: SAMPLE_W] = sample;
                    sample = sample + SAMPLE_W'(1);
                end
                xsum = xsum ^ payload;
                exp_q.push_back({KIND_DATA, payload});
            end
        end
        exp_q.push_back({KIND_CHECKSUM, xsum});
    endtask

    // compare one taken word against the reference
    task automatic check_word(input logic [WORD_W-1:0] actual);
        logic [WORD_W-1:0]  expected;
        logic               have_exp;
        have_exp = (exp_q.size() > 0);
        assert (have_exp)
        else begin
            word_err_cnt++;
            $display("%s: DUT sent word %h although no word was expected", test_name, actual);
        end
        if (have_exp) begin
            expected = exp_q.pop_front();
            assert (actual == expected)
            else begin
                mismatch_cnt++;
                $display("mismatch %s: expected %h actual %h", test_name, expected, actual);
            end
        end
        if (actual[WORD_W-1:PAYLOAD_W] == KIND_CHECKSUM)
            checksums_seen++;
    endtask

    // consumer takes the word when it first sees req then acks after a random delay
    initial begin : consumer
        int delay;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                check_word(out_word);
                draw_ack_delay(delay);
                repeat (delay) @(negedge clk);
                out_ack = 1'b1;
            end else if (!out_req && out_ack) begin
                out_ack = 1'b0;
            end
        end
    end

    task automatic report_result(input logic hung);
        int total;
        total = mismatch_cnt + word_err_cnt + flow_err_cnt
              + adc_acq_top_inst.asserts_inst.fail_cnt;
        $display("errors: %0d mismatches, %0d unexpected words, %0d flow, %0d assertions",
                 mismatch_cnt, word_err_cnt, flow_err_cnt,
                 adc_acq_top_inst.asserts_inst.fail_cnt);
        if (!hung && total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run hung and did not finish within %0d cycles", cycle_cnt);
            report_result(1'b1);
        end
    end

    // one triggered fill with write-done, retrigger hold and release
    task automatic run_fill(input string name, input fill_type_t ftype, input logic rmode);
        int seen;
        int wait_cnt;
        test_name = name;
        queue_fill(ftype, rmode);
        @(negedge clk);
        acq_enable0 = ftype[0];
        acq_enable1 = ftype[1];
        dummy_dat_reset_mode = rmode;
        // enables reach the decoded fill type before the trigger does
        repeat (SYNC_STAGES + 2) @(negedge clk);
        seen = checksums_seen;
        acq_trig = 1'b1;
        // writer done comes a few cycles after the checksum handshake closed
        // so the sequencer is already waiting on it
        wait_cnt = 0;
        while (checksums_seen == seen || out_req || out_ack || wait_cnt < WR_DONE_DELAY) begin
            @(negedge clk);
            if (checksums_seen != seen && !out_req && !out_ack)
                wait_cnt++;
            assert (!acq_done)
            else begin
                flow_err_cnt++;
                $display("%s: acq_done rose before ddr3_wr_done", name);
            end
        end
        ddr3_wr_done = 1'b1;
        while (!acq_done) @(negedge clk);
        // no second fill may start while the trigger is still high
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (acq_done && !out_req && !sm_idle)
            else begin
                flow_err_cnt++;
                $display("%s: done flag not held or a new fill started under trigger", name);
            end
        end
        acq_trig = 1'b0;
        ddr3_wr_done = 1'b0;
        while (!sm_idle) @(negedge clk);
        assert (!acq_done && exp_q.size() == 0)
        else begin
            flow_err_cnt++;
            $display("%s: fill ended with %0d words still missing", name, exp_q.size());
        end
        fills_done++;
    endtask

    // trigger is ignored with both enables low
    task automatic run_readout();
        test_name = "readout";
        @(negedge clk);
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        repeat (SYNC_STAGES + 2) @(negedge clk);
        acq_trig = 1'b1;
        repeat (SYNC_STAGES + HOLD_CYCLES) begin
            @(negedge clk);
            assert (!out_req && sm_idle)
            else begin
                flow_err_cnt++;
                $display("readout: a trigger in readout mode started a fill");
            end
        end
        acq_trig = 1'b0;
        repeat (SYNC_STAGES + 2) @(negedge clk);
    endtask

    initial begin
        adc_acq_full_reset = 1'b1;
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        ddr3_wr_done = 1'b0;
        dummy_dat_reset_mode = 1'b0;
        repeat (8) @(negedge clk);
        assert (sm_idle && !out_req && !acq_done)
        else begin
            flow_err_cnt++;
            $display("reset: outputs not at their reset values");
        end
        adc_acq_full_reset = 1'b0;
        run_fill("type1", 2'd1, 1'b0);
        run_fill("type2", 2'd2, 1'b0);
        run_fill("type3", 2'd3, 1'b0);
        run_readout();
        run_fill("type3_wfm_reset", 2'd3, 1'b1);
        run_fill("type2_wfm_reset", 2'd2, 1'b1);
        run_fill("type1_again", 2'd1, 1'b0);
        report_result(1'b0);
    end

endmodule

`default_nettype wire

// File: flist.f
logic/adc_acq_pkg.sv
logic/adc_acq_ctrl_if.sv
logic/adc_acq_sync_decode.sv
logic/adc_acq_sequencer.sv
logic/adc_acq_word_builder.sv
logic/adc_acq_top.sv
verification/adc_acq_asserts.sv
verification/adc_acq_tb.sv

// File: Makefile
SIM       := verilator
TOP       := adc_acq_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing --assert --timescale 1ns/100ps -j 0
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := Test completed successfully

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
